//--- Makefile
TOP = tb_rv64_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f rv64_core.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^=== PASS ===$$' sim.log

clean:
	rm -rf obj_dir sim.log

//--- design/rv64_core.sv
// rv64 core top, one instruction in flight, halt and trap stay set until reset
`timescale 1ns/1ps
`include "rv64_macros.svh"

module rv64_core (
  input  logic                  clock,
  input  logic                  i_rst_n,
  output logic [31:0]           o_paddr,
  output logic                  o_psel,
  output logic                  o_penable,
  input  logic [31:0]           i_prdata,
  input  logic                  i_pready,
  input  logic                  i_pslverr,
  output logic                  o_retire,
  output logic [`RV64_XLEN-1:0] o_retire_pc,
  output logic                  o_rd_we,
  output logic [4:0]            o_rd_addr,
  output logic [`RV64_XLEN-1:0] o_rd_data,
  output logic                  o_halt,
  output logic                  o_trap
);

  logic [`RV64_XLEN-1:0] pc;
  logic [31:0]           instr;
  logic                  instr_valid;
  logic                  fetch_err;
  logic [4:0]            rs1_addr;
  logic [4:0]            rs2_addr;
  logic                  dec_we;
  logic                  ebreak;
  logic                  illegal;
  logic [`RV64_XLEN-1:0] rs1_data;
  logic [`RV64_XLEN-1:0] rs2_data;
  logic [`RV64_XLEN-1:0] alu_result;
  logic [`RV64_XLEN-1:0] next_pc;
  logic                  trap_now;
  logic                  halt_now;
  logic                  halt_q;
  logic                  trap_q;
  logic                  stop;

  rv64_exu_if exu_bus ();

  assign exu_bus.rs1_val = rs1_data;
  assign exu_bus.rs2_val = rs2_data;

  assign trap_now    = instr_valid && (illegal || fetch_err); // a bus error beats any decode
  assign halt_now    = instr_valid && ebreak && !fetch_err;
  assign o_retire    = instr_valid && !trap_now;
  assign o_retire_pc = pc;
  assign o_rd_we     = o_retire && dec_we;
  assign o_rd_data   = alu_result;
  assign o_halt      = halt_q || halt_now;
  assign o_trap      = trap_q || trap_now;
  assign stop        = o_halt || o_trap; // seen in the execute cycle so no further setup starts

  always_ff @(posedge clock) begin
    if (!i_rst_n) begin
      halt_q <= 1'b0;
      trap_q <= 1'b0;
    end else begin
      halt_q <= o_halt;
      trap_q <= o_trap;
    end
  end

  rv64_ifu u_ifu (
    .clock         (clock),
    .i_rst_n       (i_rst_n),
    .i_next_pc     (next_pc),
    .i_exec_done   (o_retire),
    .i_stop        (stop),
    .o_pc          (pc),
    .o_instr       (instr),
    .o_instr_valid (instr_valid),
    .o_fetch_err   (fetch_err),
    .o_paddr       (o_paddr),
    .o_psel        (o_psel),
    .o_penable     (o_penable),
    .i_prdata      (i_prdata),
    .i_pready      (i_pready),
    .i_pslverr     (i_pslverr)
  );

  rv64_idu u_idu (
    .i_instr    (instr),
    .i_pc       (pc),
    .o_rs1_addr (rs1_addr),
    .o_rs2_addr (rs2_addr),
    .o_rd_addr  (o_rd_addr),
    .o_rd_we    (dec_we),
    .o_ebreak   (ebreak),
    .o_illegal  (illegal),
    .exu_bus    (exu_bus)
  );

  rv64_regfile u_regfile (
    .clock      (clock),
    .i_rst_n    (i_rst_n),
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_we       (o_rd_we),
    .i_rd_addr  (o_rd_addr),
    .i_rd_data  (alu_result)
  );

  rv64_exu u_exu (
    .exu_bus      (exu_bus),
    .o_alu_result (alu_result),
    .o_next_pc    (next_pc)
  );

endmodule

//--- design/rv64_exu.sv
// execute unit, combinational alu and next pc, branch compare works on rs1 and rs2 directly
`timescale 1ns/1ps
`include "rv64_macros.svh"

module rv64_exu (
  rv64_exu_if.exu               exu_bus,
  output logic [`RV64_XLEN-1:0] o_alu_result,
  output logic [`RV64_XLEN-1:0] o_next_pc
);
  import rv64_pkg::*;

  logic [`RV64_XLEN-1:0] add_a;
  logic [`RV64_XLEN-1:0] add_b;
  logic [`RV64_XLEN-1:0] sum;
  logic [`RV64_XLEN-1:0] diff;
  logic [`RV64_XLEN-1:0] word;
  logic                  less;
  logic                  rs_eq;
  logic                  rs_lt;
  logic                  take_imm;
  logic [`RV64_XLEN-1:0] pc_base;
  logic [`RV64_XLEN-1:0] pc_sum;

  assign add_a = (exu_bus.asrc == ASRC_PC) ? exu_bus.pc : exu_bus.rs1_val;

  always_comb begin
    case (exu_bus.bsrc)
      BSRC_IMM:  add_b = exu_bus.imm;
      BSRC_FOUR: add_b = `RV64_XLEN'd4;
      default:   add_b = exu_bus.rs2_val;
    endcase
  end

  assign sum  = add_a + add_b;
  assign diff = add_a - add_b;
  assign word = {{(`RV64_XLEN-32){sum[31]}}, sum[31:0]};

  // sign of the difference, corrected when the operand signs differ and the subtract overflows
  assign less = (add_a[`RV64_XLEN-1] != add_b[`RV64_XLEN-1]) ? add_a[`RV64_XLEN-1]
                                                              : diff[`RV64_XLEN-1];

  always_comb begin
    case (exu_bus.alu_op)
      ALU_SUB:   o_alu_result = diff;
      ALU_SLT:   o_alu_result = {{(`RV64_XLEN-1){1'b0}}, less};
      ALU_ADDW:  o_alu_result = word;
      ALU_COPYB: o_alu_result = add_b;
      default:   o_alu_result = sum;
    endcase
  end

  assign rs_eq = (exu_bus.rs1_val == exu_bus.rs2_val);
  assign rs_lt = ($signed(exu_bus.rs1_val) < $signed(exu_bus.rs2_val));

  always_comb begin
    case (exu_bus.branch)
      BR_JAL:  take_imm = 1'b1;
      BR_JALR: take_imm = 1'b1;
      BR_EQ:   take_imm = rs_eq;
      BR_NE:   take_imm = !rs_eq;
      BR_LT:   take_imm = rs_lt;
      BR_GE:   take_imm = !rs_lt;
      default: take_imm = 1'b0;
    endcase
  end

  assign pc_base   = (exu_bus.branch == BR_JALR) ? exu_bus.rs1_val : exu_bus.pc;
  assign pc_sum    = pc_base + (take_imm ? exu_bus.imm : `RV64_XLEN'd4);
  assign o_next_pc = (exu_bus.branch == BR_JALR) ? {pc_sum[`RV64_XLEN-1:1], 1'b0} : pc_sum;

endmodule

//--- design/rv64_exu_if.sv
// decoder to execute bundle, rs1_val and rs2_val are driven by the top level from the regfile
`timescale 1ns/1ps
`include "rv64_macros.svh"

interface rv64_exu_if;
  import rv64_pkg::*;

  logic [`RV64_XLEN-1:0] rs1_val;
  logic [`RV64_XLEN-1:0] rs2_val;
  logic [`RV64_XLEN-1:0] imm; // already sign extended by the decoder
  logic [`RV64_XLEN-1:0] pc;
  asrc_e                 asrc;
  bsrc_e                 bsrc;
  alu_op_e               alu_op;
  branch_e               branch;

  modport idu (
    output imm, pc, asrc, bsrc, alu_op, branch
  );

  modport exu (
    input rs1_val, rs2_val, imm, pc, asrc, bsrc, alu_op, branch
  );

endinterface

//--- design/rv64_idu.sv
// decoder for the lui/auipc/addi/add/sub/slt/addw/addiw/jal/jalr/branch/ebreak subset only
`timescale 1ns/1ps
`include "rv64_macros.svh"

module rv64_idu (
  input  logic [31:0]           i_instr,
  input  logic [`RV64_XLEN-1:0] i_pc,
  output logic [4:0]            o_rs1_addr,
  output logic [4:0]            o_rs2_addr,
  output logic [4:0]            o_rd_addr,
  output logic                  o_rd_we,
  output logic                  o_ebreak,
  output logic                  o_illegal,
  rv64_exu_if.idu               exu_bus
);
  import rv64_pkg::*;

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [`RV64_XLEN-1:0] imm_i;
  logic [`RV64_XLEN-1:0] imm_u;
  logic [`RV64_XLEN-1:0] imm_j;
  logic [`RV64_XLEN-1:0] imm_b;

  assign opcode     = i_instr[6:0];
  assign funct3     = i_instr[14:12];
  assign funct7     = i_instr[31:25];
  assign o_rs1_addr = i_instr[19:15];
  assign o_rs2_addr = i_instr[24:20];
  assign o_rd_addr  = i_instr[11:7];
  assign exu_bus.pc = i_pc;

  assign imm_i = {{(`RV64_XLEN-12){i_instr[31]}}, i_instr[31:20]};
  assign imm_u = {{(`RV64_XLEN-32){i_instr[31]}}, i_instr[31:12], 12'b0};
  assign imm_j = {{(`RV64_XLEN-20){i_instr[31]}}, i_instr[19:12], i_instr[20],
                  i_instr[30:21], 1'b0};
  assign imm_b = {{(`RV64_XLEN-12){i_instr[31]}}, i_instr[7], i_instr[30:25],
                  i_instr[11:8], 1'b0};

  always_comb begin
    exu_bus.imm    = imm_i;
    exu_bus.asrc   = ASRC_RS1;
    exu_bus.bsrc   = BSRC_IMM;
    exu_bus.alu_op = ALU_ADD;
    exu_bus.branch = BR_NONE;
    o_rd_we        = 1'b0;
    o_ebreak       = 1'b0;
    o_illegal      = 1'b0;
    case (opcode)
      OPC_LUI: begin
        exu_bus.imm    = imm_u;
        exu_bus.alu_op = ALU_COPYB;
        o_rd_we        = 1'b1;
      end
      OPC_AUIPC: begin
        exu_bus.imm  = imm_u;
        exu_bus.asrc = ASRC_PC;
        o_rd_we      = 1'b1;
      end
      OPC_OPIMM: begin
        o_rd_we   = (funct3 == 3'b000); // addi is the only op-imm form supported
        o_illegal = (funct3 != 3'b000);
      end
      OPC_OPIMM32: begin
        exu_bus.alu_op = ALU_ADDW;
        o_rd_we        = (funct3 == 3'b000);
        o_illegal      = (funct3 != 3'b000);
      end
      OPC_OP: begin
        exu_bus.bsrc = BSRC_RS2;
        o_rd_we      = 1'b1;
        if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          exu_bus.alu_op = ALU_SUB;
        end else if (funct7 == 7'b0000000 && funct3 == 3'b010) begin
          exu_bus.alu_op = ALU_SLT;
        end else if (!(funct7 == 7'b0000000 && funct3 == 3'b000)) begin
          o_rd_we   = 1'b0;
          o_illegal = 1'b1;
        end
      end
      OPC_OP32: begin
        exu_bus.bsrc   = BSRC_RS2;
        exu_bus.alu_op = ALU_ADDW;
        o_rd_we        = (funct7 == 7'b0000000 && funct3 == 3'b000);
        o_illegal      = !(funct7 == 7'b0000000 && funct3 == 3'b000);
      end
      OPC_JAL: begin
        exu_bus.imm    = imm_j;
        exu_bus.asrc   = ASRC_PC;
        exu_bus.bsrc   = BSRC_FOUR; // alu forms the link value pc+4
        exu_bus.branch = BR_JAL;
        o_rd_we        = 1'b1;
      end
      OPC_JALR: begin
        exu_bus.asrc   = ASRC_PC;
        exu_bus.bsrc   = BSRC_FOUR;
        exu_bus.branch = BR_JALR;
        o_rd_we        = (funct3 == 3'b000);
        o_illegal      = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        exu_bus.imm  = imm_b;
        exu_bus.bsrc = BSRC_RS2;
        case (funct3)
          3'b000:  exu_bus.branch = BR_EQ;
          3'b001:  exu_bus.branch = BR_NE;
          3'b100:  exu_bus.branch = BR_LT;
          3'b101:  exu_bus.branch = BR_GE;
          default: o_illegal = 1'b1;
        endcase
      end
      OPC_SYSTEM: begin
        o_ebreak  = (i_instr == 32'h0010_0073);
        o_illegal = (i_instr != 32'h0010_0073); // ecall and the csr forms trap
      end
      default: begin
        o_illegal = 1'b1;
      end
    endcase
  end

endmodule

//--- design/rv64_ifu.sv
// apb read-only fetch unit, one transfer per instruction, only pc[31:0] reaches the bus
`timescale 1ns/1ps
`include "rv64_macros.svh"

module rv64_ifu (
  input  logic                  clock,
  input  logic                  i_rst_n,
  input  logic [`RV64_XLEN-1:0] i_next_pc,
  input  logic                  i_exec_done,
  input  logic                  i_stop,
  output logic [`RV64_XLEN-1:0] o_pc,
  output logic [31:0]           o_instr,
  output logic                  o_instr_valid,
  output logic                  o_fetch_err,
  output logic [31:0]           o_paddr,
  output logic                  o_psel,
  output logic                  o_penable,
  input  logic [31:0]           i_prdata,
  input  logic                  i_pready,
  input  logic                  i_pslverr
);

  typedef enum logic [1:0] {
    S_SETUP  = 2'd0,
    S_ACCESS = 2'd1,
    S_EXEC   = 2'd2
  } state_e;

  state_e state_q;
  logic   fetch_done;

  assign fetch_done = (state_q == S_ACCESS) && i_pready; // psel and penable are both high here
  assign o_psel     = (state_q == S_SETUP) || (state_q == S_ACCESS);
  assign o_penable  = (state_q == S_ACCESS);
  assign o_paddr    = o_pc[31:0]; // pc only moves in the execute cycle, so it holds over the transfer

  // reset parks the fsm in execute-wait so the bus stays quiet until reset is released
  always_ff @(posedge clock) begin
    if (!i_rst_n) begin
      state_q       <= S_EXEC;
      o_pc          <= `RV64_RESET_PC;
      o_instr_valid <= 1'b0;
      o_fetch_err   <= 1'b0;
    end else begin
      o_instr_valid <= fetch_done; // single cycle pulse marks the execute cycle
      case (state_q)
        S_SETUP: begin
          state_q <= S_ACCESS;
        end
        S_ACCESS: begin
          if (i_pready) begin
            state_q     <= S_EXEC;
            o_fetch_err <= i_pslverr;
          end
        end
        default: begin
          if (i_exec_done) begin
            o_pc <= i_next_pc;
          end
          if (!i_stop) begin
            state_q <= S_SETUP; // a halted or trapped core stays here until reset
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_done) begin
      o_instr <= i_prdata;
    end
  end

endmodule

//--- design/rv64_macros.svh
// width and reset constants for the rv64 core, the reset pc must stay word aligned
`ifndef RV64_MACROS_SVH
`define RV64_MACROS_SVH

// data path width in bits
`define RV64_XLEN 64

// address of the first fetch after reset
`define RV64_RESET_PC 64'h0000_0000_0000_0000

// number of integer registers, x0 included
`define RV64_NREGS 32

`endif

//--- design/rv64_pkg.sv
// shared decode types for the rv64 core, only the small integer subset has opcodes here
package rv64_pkg;

  typedef enum logic [2:0] {
    ALU_ADD   = 3'd0,
    ALU_SUB   = 3'd1,
    ALU_SLT   = 3'd2,
    ALU_ADDW  = 3'd3, // 32 bit sum sign extended to 64
    ALU_COPYB = 3'd4  // passes operand b through, used by lui
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE = 3'b000,
    BR_JAL  = 3'b001,
    BR_JALR = 3'b010,
    BR_EQ   = 3'b100,
    BR_NE   = 3'b101,
    BR_LT   = 3'b110,
    BR_GE   = 3'b111
  } branch_e;

  typedef enum logic {
    ASRC_RS1 = 1'b0,
    ASRC_PC  = 1'b1
  } asrc_e;

  typedef enum logic [1:0] {
    BSRC_RS2  = 2'b00,
    BSRC_IMM  = 2'b01,
    BSRC_FOUR = 2'b10
  } bsrc_e;

  localparam logic [6:0] OPC_LUI     = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
  localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP      = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM32 = 7'b0011011;
  localparam logic [6:0] OPC_OP32    = 7'b0111011;
  localparam logic [6:0] OPC_JAL     = 7'b1101111;
  localparam logic [6:0] OPC_JALR    = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
  localparam logic [6:0] OPC_SYSTEM  = 7'b1110011;

endpackage

//--- design/rv64_regfile.sv
// integer register file, two asynchronous reads, one write port, x0 never written
`timescale 1ns/1ps
`include "rv64_macros.svh"

module rv64_regfile (
  input  logic                           clock,
  input  logic                           i_rst_n,
  input  logic [$clog2(`RV64_NREGS)-1:0] i_rs1_addr,
  input  logic [$clog2(`RV64_NREGS)-1:0] i_rs2_addr,
  output logic [`RV64_XLEN-1:0]          o_rs1_data,
  output logic [`RV64_XLEN-1:0]          o_rs2_data,
  input  logic                           i_we,
  input  logic [$clog2(`RV64_NREGS)-1:0] i_rd_addr,
  input  logic [`RV64_XLEN-1:0]          i_rd_data
);

  logic [`RV64_XLEN-1:0] regs [`RV64_NREGS];

  assign o_rs1_data = regs[i_rs1_addr];
  assign o_rs2_data = regs[i_rs2_addr];

  always_ff @(posedge clock) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `RV64_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd_addr != '0)) begin
      regs[i_rd_addr] <= i_rd_data; // x0 keeps its reset value of zero
    end
  end

endmodule

//--- rv64_core.f
+incdir+design
design/rv64_pkg.sv
design/rv64_exu_if.sv
design/rv64_ifu.sv
design/rv64_idu.sv
design/rv64_regfile.sv
design/rv64_exu.sv
design/rv64_core.sv
test/tb_rv64_core.sv

//--- test/tb_rv64_core.sv
// self-checking testbench, the memory model holds 64 words so fetches wrap at 256 bytes
`timescale 1ns/1ps
`include "rv64_macros.svh"

module tb_rv64_core;
  import rv64_pkg::*;

  localparam logic [31:0] EBREAK = 32'h0010_0073;

  logic                  clock = 1'b0;
  logic                  i_rst_n;
  logic [31:0]           o_paddr;
  logic                  o_psel;
  logic                  o_penable;
  logic [31:0]           i_prdata;
  logic                  i_pready;
  logic                  i_pslverr;
  logic                  o_retire;
  logic [`RV64_XLEN-1:0] o_retire_pc;
  logic                  o_rd_we;
  logic [4:0]            o_rd_addr;
  logic [`RV64_XLEN-1:0] o_rd_data;
  logic                  o_halt;
  logic                  o_trap;

  logic [31:0]           mem [64];
  logic [31:0]           bad_addr;
  int                    load_idx;
  int                    budget_cycles = 16;
  int                    passed;
  int                    failed;

  // reference model state, owned by the checker process
  logic [`RV64_XLEN-1:0] xreg [32];
  logic [`RV64_XLEN-1:0] mpc;
  logic                  stopped;
  int                    retired;
  int                    err_cnt;
  logic                  prev_rst_n = 1'b0;
  logic                  prev_psel;
  logic                  prev_penable;
  logic                  prev_pready;
  logic [31:0]           prev_paddr;

  always #4 clock = ~clock;

  rv64_core u_dut (
    .clock       (clock),
    .i_rst_n     (i_rst_n),
    .o_paddr     (o_paddr),
    .o_psel      (o_psel),
    .o_penable   (o_penable),
    .i_prdata    (i_prdata),
    .i_pready    (i_pready),
    .i_pslverr   (i_pslverr),
    .o_retire    (o_retire),
    .o_retire_pc (o_retire_pc),
    .o_rd_we     (o_rd_we),
    .o_rd_addr   (o_rd_addr),
    .o_rd_data   (o_rd_data),
    .o_halt      (o_halt),
    .o_trap      (o_trap)
  );

  function automatic logic [31:0] enc_r(input logic [6:0] opc, input int f3, input int f7,
                                        input int rd, input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input int f3, input int rd,
                                        input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] opc, input int rd, input int imm);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_b(input int f3, input int rs1, input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
  endfunction

  function automatic logic [63:0] sext32(input logic [63:0] v);
    return {{32{v[31]}}, v[31:0]};
  endfunction

  task automatic clear_mem();
    for (int i = 0; i < 64; i++) begin
      mem[i[5:0]] = {i[24:0], 7'h7f}; // opcode 7f is illegal, so a stray fetch traps
    end
    load_idx = 0;
  endtask

  task automatic put_word(input logic [31:0] w);
    mem[load_idx[5:0]] = w;
    load_idx++;
  endtask

  task automatic fail_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    err_cnt++;
    $display("ERR %s got 0x%h exp 0x%h at pc 0x%h", name, got, exp, mpc);
  endtask

  task automatic fail_words(input string what);
    err_cnt++;
    $display("error at %0t ns: %s", $time, what);
  endtask

  // apb memory, 0 to 3 wait states per access, inputs move 1 ns after the rising edge
  initial begin
    int wait_left;
    wait_left = 0;
    i_prdata  = 32'd0;
    i_pready  = 1'b0;
    i_pslverr = 1'b0;
    void'($urandom(43317));
    forever begin
      @(posedge clock);
      #1;
      i_pready  = 1'b0;
      i_pslverr = 1'b0;
      if (o_psel === 1'b1 && o_penable === 1'b0) begin
        wait_left = $urandom_range(3, 0);
      end else if (o_psel === 1'b1 && o_penable === 1'b1) begin
        if (wait_left == 0) begin
          i_pready  = 1'b1;
          i_prdata  = mem[o_paddr[7:2]];
          i_pslverr = (o_paddr == bad_addr);
        end else begin
          wait_left = wait_left - 1;
        end
      end
    end
  end

  // predicts one instruction from the isa rules and compares with the retire ports
  task automatic check_step();
    logic [31:0] w;
    logic [4:0]  rd;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm_i;
    logic [63:0] imm_b;
    logic [63:0] res;
    logic [63:0] npc;
    logic        we;
    logic        ill;
    logic        brk;
    logic        trap;
    w     = mem[mpc[7:2]];
    rd    = w[11:7];
    a     = xreg[w[19:15]];
    b     = xreg[w[24:20]];
    imm_i = {{52{w[31]}}, w[31:20]};
    imm_b = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    res   = '0;
    npc   = mpc + 64'd4;
    we    = 1'b1;
    ill   = 1'b0;
    brk   = 1'b0;
    case (w[6:0])
      OPC_LUI:   res = {{32{w[31]}}, w[31:12], 12'h000};
      OPC_AUIPC: res = mpc + {{32{w[31]}}, w[31:12], 12'h000};
      OPC_OPIMM: begin
        res = a + imm_i;
        ill = (w[14:12] != 3'd0);
      end
      OPC_OPIMM32: begin
        res = sext32(a + imm_i);
        ill = (w[14:12] != 3'd0);
      end
      OPC_OP: begin
        case ({w[31:25], w[14:12]})
          10'b0000000_000: res = a + b;
          10'b0100000_000: res = a - b;
          10'b0000000_010: res = {63'd0, $signed(a) < $signed(b)};
          default:         ill = 1'b1;
        endcase
      end
      OPC_OP32: begin
        res = sext32(a + b);
        ill = ({w[31:25], w[14:12]} != 10'd0);
      end
      OPC_JAL: begin
        res = mpc + 64'd4;
        npc = mpc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      OPC_JALR: begin
        res = mpc + 64'd4;
        npc = (a + imm_i) & ~64'd1;
        ill = (w[14:12] != 3'd0);
      end
      OPC_BRANCH: begin
        we = 1'b0;
        case (w[14:12])
          3'd0:    npc = (a == b) ? mpc + imm_b : npc;
          3'd1:    npc = (a != b) ? mpc + imm_b : npc;
          3'd4:    npc = ($signed(a) < $signed(b)) ? mpc + imm_b : npc;
          3'd5:    npc = ($signed(a) >= $signed(b)) ? mpc + imm_b : npc;
          default: ill = 1'b1;
        endcase
      end
      OPC_SYSTEM: begin
        we  = 1'b0;
        brk = (w == EBREAK);
        ill = !brk;
      end
      default: ill = 1'b1;
    endcase
    trap = ill || (mpc[31:0] == bad_addr);
    retired++;
    assert (o_trap == trap) else fail_value("o_trap", 64'(o_trap), 64'(trap));
    if (trap) begin
      assert (!o_retire && !o_rd_we) else fail_words("trapped instruction retired or wrote rd");
      stopped = 1'b1;
    end else begin
      assert (o_retire) else fail_words("instruction finished without o_retire");
      assert (o_retire_pc == mpc) else fail_value("o_retire_pc", o_retire_pc, mpc);
      assert (o_rd_we == we) else fail_value("o_rd_we", 64'(o_rd_we), 64'(we));
      if (we) begin
        assert (o_rd_addr == rd) else fail_value("o_rd_addr", 64'(o_rd_addr), 64'(rd));
        assert (o_rd_data == res) else fail_value("o_rd_data", o_rd_data, res);
      end
      assert (o_halt == brk) else fail_value("o_halt", 64'(o_halt), 64'(brk));
      if (we && rd != 5'd0) begin
        xreg[rd] = res;
      end
      mpc     = npc;
      stopped = brk;
    end
  endtask

  // all checks run at the falling edge where the core outputs are settled
  always @(negedge clock) begin
    if (!i_rst_n) begin
      for (int r = 0; r < 32; r++) begin
        xreg[r] = '0;
      end
      mpc     = `RV64_RESET_PC;
      stopped = 1'b0;
      retired = 0;
    end else begin
      if (!prev_rst_n) begin
        assert (o_psel === 1'b0 && o_penable === 1'b0 && o_retire === 1'b0 &&
                o_halt === 1'b0 && o_trap === 1'b0)
          else fail_words("core outputs not idle after reset");
      end
      if (o_penable) begin
        assert (prev_psel && o_psel) else fail_words("o_penable raised without a setup cycle");
      end
      if (prev_psel && prev_penable && !prev_pready) begin
        assert (o_paddr == prev_paddr) else fail_value("o_paddr", 64'(o_paddr), 64'(prev_paddr));
      end
      assert (!(o_retire && o_psel)) else fail_words("fetch started during a retire cycle");
      if (o_halt || o_trap) begin
        assert (!o_psel) else fail_words("fetch started after halt or trap");
      end
      if (!stopped && (o_retire || o_trap)) begin
        check_step();
      end
    end
    prev_rst_n   = i_rst_n;
    prev_psel    = o_psel;
    prev_penable = o_penable;
    prev_pready  = i_pready;
    prev_paddr   = o_paddr;
  end

  initial begin
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clock);
      cycles++;
      if (cycles > budget_cycles) begin
        $display("timeout: core did not halt or trap within %0d cycles", budget_cycles);
        $display("=== FAIL ===");
        $finish;
      end
    end
  end

  task automatic run_test(input string name, input logic expect_trap);
    int   errs_before;
    logic ended_ok;
    errs_before   = err_cnt;
    budget_cycles = budget_cycles + 20 * 4 * load_idx + 8; // worst case is 6 cycles each
    @(posedge clock);
    #1 i_rst_n = 1'b0;
    repeat (3) @(posedge clock);
    #1 i_rst_n = 1'b1;
    @(negedge clock);
    while (!stopped) @(negedge clock);
    repeat (4) @(negedge clock); // psel must stay low here
    #1;
    ended_ok = (o_trap == expect_trap) && (o_halt == !expect_trap);
    assert (ended_ok) else $display("test %s ended with halt %0b and trap %0b, not as expected",
                                    name, o_halt, o_trap);
    if (ended_ok && err_cnt == errs_before) begin
      passed++;
      $display("test %s passed, %0d instructions checked", name, retired);
    end else begin
      failed++;
      $display("test %s failed, %0d errors", name, err_cnt - errs_before);
    end
  endtask

  initial begin
    i_rst_n  = 1'b0;
    bad_addr = 32'hffff_ffff;
    passed   = 0;
    failed   = 0;
    err_cnt  = 0;

    clear_mem(); // operands chosen to overflow 32 bits
    put_word(enc_u(OPC_LUI, 1, 'h80000));
    put_word(enc_i(OPC_OPIMM, 0, 1, 1, -1));
    put_word(enc_u(OPC_LUI, 2, 'h7ffff));
    put_word(enc_i(OPC_OPIMM, 0, 2, 2, 'h7ff));
    put_word(enc_r(OPC_OP32, 0, 0, 3, 2, 2));
    put_word(enc_r(OPC_OP, 0, 0, 4, 2, 2));
    put_word(enc_i(OPC_OPIMM32, 0, 5, 4, 1));
    put_word(enc_r(OPC_OP, 0, 'h20, 6, 1, 2));
    put_word(enc_r(OPC_OP, 2, 0, 7, 1, 2));
    put_word(enc_r(OPC_OP, 2, 0, 8, 2, 1));
    put_word(enc_u(OPC_AUIPC, 9, 'h12345));
    put_word(EBREAK);
    run_test("alu", 1'b0);

    clear_mem(); // each branch kind once taken and once not
    put_word(enc_i(OPC_OPIMM, 0, 1, 0, -5));
    put_word(enc_i(OPC_OPIMM, 0, 2, 0, 9));
    put_word(enc_i(OPC_OPIMM, 0, 3, 0, 9));
    put_word(enc_b(0, 2, 3, 8));
    put_word(32'h0000_0000);
    put_word(enc_b(0, 1, 2, 8));
    put_word(enc_b(1, 1, 2, 8));
    put_word(32'h0000_0000);
    put_word(enc_b(1, 2, 3, 8));
    put_word(enc_b(4, 1, 2, 8));
    put_word(32'h0000_0000);
    put_word(enc_b(4, 2, 1, 8));
    put_word(enc_b(5, 2, 1, 8));
    put_word(32'h0000_0000);
    put_word(enc_b(5, 1, 2, 8));
    put_word(enc_b(5, 2, 3, 8));
    put_word(32'h0000_0000);
    put_word(EBREAK);
    run_test("branch", 1'b0);

    clear_mem();
    put_word(enc_i(OPC_OPIMM, 0, 12, 0, 21)); // odd base, jalr clears bit 0
    put_word(enc_j(11, 12));
    put_word(EBREAK);
    put_word(32'h0000_0000);
    put_word(enc_i(OPC_JALR, 0, 13, 12, 4));
    put_word(32'h0000_0000);
    put_word(enc_j(0, 8));
    put_word(32'h0000_0000);
    put_word(enc_i(OPC_OPIMM, 0, 14, 0, 5));
    put_word(enc_r(OPC_OP, 0, 0, 15, 0, 11));
    put_word(enc_j(1, -32));
    run_test("jump", 1'b0);

    clear_mem();
    put_word(enc_i(OPC_OPIMM, 0, 1, 0, 7));
    put_word(enc_r(OPC_OP, 1, 0, 2, 1, 1)); // sll is outside the subset
    put_word(EBREAK);
    run_test("illegal", 1'b1);

    clear_mem();
    put_word(enc_i(OPC_OPIMM, 0, 1, 0, 3));
    put_word(enc_i(OPC_OPIMM, 0, 2, 0, 4));
    put_word(EBREAK);
    bad_addr = 32'h0000_0004;
    run_test("buserr", 1'b1);

    $display("summary: %0d tests passed, %0d failed, %0d errors", passed, failed, err_cnt);
    if (failed == 0 && err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
